// File: all.f
verilog/ledd_pkg.sv
verilog/ledd_ctrl.sv
verilog/ledd_pwm_cnt.sv
verilog/ledd_pwmc.sv
verilog/ledd_top.sv
verification/tb_ledd.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the LED driver testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_ledd -o sim_ledd
if [ $? -ne 0 ]; then
   echo "Verilator build returned an error"
   exit 1
fi

sim_out=$(./obj_dir/sim_ledd)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulator exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Simulation completed successfully"; then
   exit 0
fi
exit 1

// File: verification/tb_ledd.sv
`timescale 1ns/1ps
module tb_ledd;
   import ledd_pkg::*;

   localparam int FRAME_NS    = 256 * 20;
   localparam int PHASES      = 8;                        // Idle, five steady, off, breathing
   localparam int WATCHDOG_NS = 40 * PHASES * FRAME_NS;

   logic        ledd_clk = 1'b0;
   logic        ledd_rst_async;
   logic        cfg_valid;
   logic        cfg_on;
   logic        cfg_breath;
   logic        cfg_extend;
   pwm_t        cfg_level;
   rate_t       cfg_rate;
   logic        cfg_ready;
   logic        pwm_out;
   logic        frame_sync;

   logic [31:0] seed = 32'heb57_c1d2;
   int          errors = 0;

   // Configuration as seen by the DUT at acceptance
   logic        accepted_any = 1'b0;
   logic        cur_on = 1'b0;
   logic        cur_breath = 1'b0;
   logic        cur_ext = 1'b0;
   pwm_t        cur_level = '0;

   // Frame measurement
   logic [8:0]  hi_acc = '0;
   logic [8:0]  meas = '0;
   logic [8:0]  meas_prev = '0;
   logic        meas_vld = 1'b0;
   int          frame_idx = 0;        // Frames completed since acceptance
   int          cyc_since = 0;
   int          ready_low = 0;
   logic        dir_up = 1'b0;
   logic        dir_vld = 1'b0;
   logic        seen_top = 1'b0;
   logic        seen_zero = 1'b0;
   logic        seen_rise = 1'b0;

   wire         accept_now = cfg_valid && cfg_ready;

   ledd_top u_dut (.*);

   always #10 ledd_clk = ~ledd_clk;

   function automatic logic [31:0] lcg_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // High cycles per frame in steady mode
   function automatic logic [8:0] steady_count(input pwm_t lvl, input logic ext);
      return (lvl == 8'hFF && ext) ? 9'd256 : {1'b0, lvl};
   endfunction

   task automatic send_cfg(input logic on, input logic breath, input logic ext,
                           input pwm_t lvl, input rate_t rt);
      cfg_valid  <= 1'b1;
      cfg_on     <= on;
      cfg_breath <= breath;
      cfg_extend <= ext;
      cfg_level  <= lvl;
      cfg_rate   <= rt;
      @(posedge ledd_clk);
      while (!cfg_ready)
         @(posedge ledd_clk);        // Hold until taken
      cfg_valid <= 1'b0;
      @(posedge ledd_clk);
   endtask

   always @(posedge ledd_clk)
   begin
      meas_vld  <= 1'b0;
      ready_low <= cfg_ready ? 0 : ready_low + 1;
      if (frame_sync)
      begin
         meas      <= hi_acc + {8'h00, pwm_out};   // Window closes on frame_sync
         meas_prev <= meas;
         meas_vld  <= 1'b1;
         hi_acc    <= '0;
      end
      else
         hi_acc <= hi_acc + {8'h00, pwm_out};
      if (meas_vld && cur_on && cur_breath && frame_idx >= 2)
      begin
         if (frame_idx >= 3 && meas != meas_prev)
         begin
            dir_up  <= (meas > meas_prev);
            dir_vld <= 1'b1;
         end
         if (meas == {1'b0, cur_level})
            seen_top <= 1'b1;
         if (seen_top && meas == 9'd0)
            seen_zero <= 1'b1;
         if (seen_zero && meas != 9'd0)
            seen_rise <= 1'b1;                    // Second ramp started
      end
      if (accept_now)
      begin
         accepted_any <= 1'b1;
         cur_on       <= cfg_on;
         cur_breath   <= cfg_breath;
         cur_ext      <= cfg_extend;
         cur_level    <= cfg_level;
         frame_idx    <= 0;
         cyc_since    <= 0;
         dir_vld      <= 1'b0;
         seen_top     <= 1'b0;
         seen_zero    <= 1'b0;
         seen_rise    <= 1'b0;
      end
      else
      begin
         if (frame_sync)
            frame_idx <= frame_idx + 1;
         cyc_since <= cyc_since + 1;
      end
   end

   a_reset_ready: assert property (@(posedge ledd_clk) disable iff (ledd_rst_async)
      !accepted_any |-> cfg_ready)
      else begin
         errors++;
         $display("CHECK FAILED cfg_ready expected %h got %h", 1'b1, $sampled(cfg_ready));
      end

   a_reset_quiet: assert property (@(posedge ledd_clk) disable iff (ledd_rst_async)
      !accepted_any |-> !pwm_out && !frame_sync)
      else begin
         errors++;
         $display("CHECK FAILED pwm_out/frame_sync expected 0/0 got %h/%h",
                  $sampled(pwm_out), $sampled(frame_sync));
      end

   // Step calculation holds off the host for at most eight cycles
   a_calc_bound: assert property (@(posedge ledd_clk) disable iff (ledd_rst_async)
      !cfg_ready |-> ready_low < 8)
      else begin
         errors++;
         $display("CHECK FAILED cfg_ready low cycles expected <= %h got %h",
                  8, $sampled(ready_low) + 1);
      end

   a_off_low: assert property (@(posedge ledd_clk) disable iff (ledd_rst_async)
      accepted_any && !cur_on && cyc_since >= 512 |-> !pwm_out)
      else begin
         errors++;
         $display("CHECK FAILED pwm_out expected %h got %h", 1'b0, $sampled(pwm_out));
      end

   a_steady_duty: assert property (@(posedge ledd_clk) disable iff (ledd_rst_async)
      meas_vld && cur_on && !cur_breath && frame_idx >= 2
         |-> meas == steady_count(cur_level, cur_ext))
      else begin
         errors++;
         $display("CHECK FAILED pwm_out high count expected %h got %h",
                  steady_count(cur_level, cur_ext), $sampled(meas));
      end

   a_breath_max: assert property (@(posedge ledd_clk) disable iff (ledd_rst_async)
      meas_vld && cur_on && cur_breath && frame_idx >= 2 |-> meas <= {1'b0, cur_level})
      else begin
         errors++;
         $display("CHECK FAILED pwm_out high count expected <= %h got %h",
                  cur_level, $sampled(meas));
      end

   // Ramp turns only at the ends of its range
   a_turn_up: assert property (@(posedge ledd_clk) disable iff (ledd_rst_async)
      meas_vld && cur_on && cur_breath && dir_vld && !dir_up && meas > meas_prev
         |-> meas_prev == 9'd0)
      else begin
         errors++;
         $display("CHECK FAILED pwm_out turn-up count expected %h got %h",
                  9'd0, $sampled(meas_prev));
      end

   a_turn_down: assert property (@(posedge ledd_clk) disable iff (ledd_rst_async)
      meas_vld && cur_on && cur_breath && dir_vld && dir_up && meas < meas_prev
         |-> meas_prev == {1'b0, cur_level})
      else begin
         errors++;
         $display("CHECK FAILED pwm_out turn-down count expected %h got %h",
                  cur_level, $sampled(meas_prev));
      end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Timeout after %0d ns, the stimulus did not finish", WATCHDOG_NS);
      $display("Errors: %0d", errors);
      $display("Simulation failed");
      $finish;
   end

   initial
   begin
      logic [31:0] r;
      pwm_t        lvl;
      rate_t       rt;
      ledd_rst_async <= 1'b1;
      cfg_valid      <= 1'b0;
      cfg_on         <= 1'b0;
      cfg_breath     <= 1'b0;
      cfg_extend     <= 1'b0;
      cfg_level      <= '0;
      cfg_rate       <= '0;
      repeat (4) @(posedge ledd_clk);
      ledd_rst_async <= 1'b0;
      repeat (600) @(posedge ledd_clk);   // Quiet until configured

      repeat (3)
      begin
         r = lcg_next();
         send_cfg(1'b1, 1'b0, r[0], r[15:8], 3'd0);
         wait (frame_idx >= 4);
      end
      send_cfg(1'b1, 1'b0, 1'b1, 8'hFF, 3'd0);
      wait (frame_idx >= 4);
      send_cfg(1'b1, 1'b0, 1'b0, 8'hFF, 3'd0);
      wait (frame_idx >= 4);

      send_cfg(1'b0, 1'b0, 1'b0, 8'h00, 3'd0);
      repeat (600) @(posedge ledd_clk);

      r   = lcg_next();
      lvl = r[23:16];
      if (lvl == 8'h00)
         lvl = 8'h01;
      rt = 3'd3 + r[10:8] % 3'd5;          // Rates 3 to 7
      send_cfg(1'b1, 1'b1, 1'b0, lvl, rt);
      wait (seen_rise);
      repeat (2) @(posedge ledd_clk);

      $display("Errors: %0d", errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// File: verilog/ledd_ctrl.sv
`timescale 1ns/1ps
module ledd_ctrl
(
   input  logic             ledd_clk,
   input  logic             ledd_rst_async,
   input  logic             cfg_valid,
   input  logic             cfg_on,
   input  logic             cfg_breath,
   input  logic             cfg_extend,
   input  ledd_pkg::pwm_t   cfg_level,
   input  ledd_pkg::rate_t  cfg_rate,
   input  logic             frame_end,
   input  logic             at_top,
   input  logic             at_zero,
   output logic             cfg_ready,
   output logic             run,
   output logic             breathing,
   output logic             extend,
   output ledd_pkg::pwm_t   level,
   output logic             mult_rst,
   output logic             mult_run,
   output logic             accum_rst,
   output logic             accum_add,
   output logic             accum_sub
);
   import ledd_pkg::*;

   ctrl_state_t state;
   ctrl_state_t state_nxt;
   rate_t       rate;        // Stored shift count
   rate_t       calc_cnt;    // Cycles spent in ST_CALC
   logic        accept;

   assign cfg_ready = (state != ST_CALC);   // Only back-pressure point
   assign accept    = cfg_valid && cfg_ready;
   assign run       = (state != ST_IDLE);

   // Stored copy of the configuration
   always_ff @(posedge ledd_clk or posedge ledd_rst_async)
   begin
      if (ledd_rst_async)
      begin
         breathing <= 1'b0;
         extend    <= 1'b0;
         level     <= '0;
         rate      <= '0;
      end
      else if (accept)
      begin
         breathing <= cfg_breath;
         extend    <= cfg_extend;
         level     <= cfg_level;
         rate      <= cfg_rate;
      end
   end

   // Next state and strobes
   always_comb
   begin
      state_nxt = state;
      mult_rst  = 1'b0;
      mult_run  = 1'b0;
      accum_rst = 1'b0;
      accum_add = 1'b0;
      accum_sub = 1'b0;
      case (state)
         ST_CALC:
         begin
            if (calc_cnt == 3'd0)
               mult_rst = 1'b1;     // Load base step
            else
               mult_run = 1'b1;     // One shift per cycle
            if (calc_cnt == rate)
            begin
               accum_rst = 1'b1;
               state_nxt = ST_RAMP_UP;
            end
         end
         ST_RAMP_UP:
         begin
            if (frame_end)
            begin
               if (at_top)
                  state_nxt = ST_RAMP_DOWN;
               else
                  accum_add = 1'b1;
            end
         end
         ST_RAMP_DOWN:
         begin
            if (frame_end)
            begin
               if (at_zero)
                  state_nxt = ST_RAMP_UP;
               else
                  accum_sub = 1'b1;
            end
         end
         default:
         begin
         end
      endcase

      // A new configuration overrides the ramp
      if (accept)
      begin
         accum_add = 1'b0;
         accum_sub = 1'b0;
         if (!cfg_on)
         begin
            state_nxt = ST_IDLE;
            accum_rst = 1'b1;
         end
         else if (!cfg_breath)
            state_nxt = ST_STEADY;
         else
            state_nxt = ST_CALC;
      end
   end

   always_ff @(posedge ledd_clk or posedge ledd_rst_async)
   begin
      if (ledd_rst_async)
      begin
         state    <= ST_IDLE;
         calc_cnt <= '0;
      end
      else
      begin
         state <= state_nxt;
         if (state != ST_CALC)
            calc_cnt <= '0;
         else
            calc_cnt <= calc_cnt + 3'd1;
      end
   end

   // Accumulator commands never collide
   a_accum_onehot: assert property (@(posedge ledd_clk) disable iff (ledd_rst_async)
      $onehot0({accum_rst, accum_add, accum_sub}))
      else $error("accumulator strobes overlap");

   a_mult_run_calc: assert property (@(posedge ledd_clk) disable iff (ledd_rst_async)
      mult_run |-> (state == ST_CALC) && $past(state == ST_CALC))
      else $error("mult_run outside step calculation");

endmodule

// File: verilog/ledd_pkg.sv
package ledd_pkg;

   // Brightness level, frame count and duty destination
   typedef logic [7:0] pwm_t;

   // Breathing accumulator, upper byte is the live duty
   typedef logic [15:0] accum_t;

   // Ramp step added or removed once per frame
   typedef logic [15:0] step_t;

   // Ramp rate as a left shift count of the step
   typedef logic [2:0] rate_t;

   typedef enum logic [2:0]
   {
      ST_IDLE,       // Output off, counter held
      ST_STEADY,     // Fixed duty
      ST_CALC,       // Step calculation in progress
      ST_RAMP_UP,
      ST_RAMP_DOWN
   } ctrl_state_t;

   // Last count of a frame
   localparam pwm_t PWM_MAX = 8'hFF;

endpackage

// File: verilog/ledd_pwm_cnt.sv
`timescale 1ns/1ps
module ledd_pwm_cnt
(
   input  logic            ledd_clk,
   input  logic            ledd_rst_async,
   input  logic            run,
   output ledd_pkg::pwm_t  pwm_cnt,
   output logic            frame_end,
   output logic            frame_sync
);
   import ledd_pkg::*;

   // Free-running frame counter, parked at zero when stopped
   always_ff @(posedge ledd_clk or posedge ledd_rst_async)
   begin
      if (ledd_rst_async)
         pwm_cnt <= '0;
      else if (!run)
         pwm_cnt <= '0;
      else
         pwm_cnt <= pwm_cnt + 8'd1;
   end

   assign frame_end = run && (pwm_cnt == PWM_MAX);   // Last cycle of frame

   // Aligned with the registered PWM output
   always_ff @(posedge ledd_clk or posedge ledd_rst_async)
   begin
      if (ledd_rst_async)
         frame_sync <= 1'b0;
      else
         frame_sync <= frame_end;
   end

   // Frame end needs the counter to have been running
   a_frame_end_run: assert property (@(posedge ledd_clk) disable iff (ledd_rst_async)
      frame_end |-> run && $past(run))
      else $error("frame_end without run");

endmodule

// File: verilog/ledd_pwmc.sv
`timescale 1ns/1ps
module ledd_pwmc
(
   input  logic            ledd_clk,
   input  logic            ledd_rst_async,
   input  logic            run,
   input  logic            breathing,
   input  logic            extend,
   input  ledd_pkg::pwm_t  level,
   input  ledd_pkg::pwm_t  pwm_cnt,
   input  logic            mult_rst,
   input  logic            mult_run,
   input  logic            accum_rst,
   input  logic            accum_add,
   input  logic            accum_sub,
   output logic            pwm_out,
   output logic            at_top,
   output logic            at_zero
);
   import ledd_pkg::*;

   accum_t      accum;
   step_t       step;
   logic [16:0] add_sum;      // Carry out marks overflow
   logic        sub_borrow;
   pwm_t        duty;         // Live breathing duty
   pwm_t        dest;
   logic        pwm_val;

   // Step is the level shifted left once per rate count
   always_ff @(posedge ledd_clk or posedge ledd_rst_async)
   begin
      if (ledd_rst_async)
         step <= '0;
      else if (mult_rst)
         step <= {8'h00, (level == 8'h00) ? PWM_MAX : level};
      else if (mult_run)
         step <= {step[14:0], 1'b0};
   end

   assign add_sum    = {1'b0, accum} + {1'b0, step};
   assign sub_borrow = (step > accum);

   always_ff @(posedge ledd_clk or posedge ledd_rst_async)
   begin
      if (ledd_rst_async)
         accum <= '0;
      else if (accum_rst)
         accum <= '0;
      else if (accum_add)
      begin
         if (!add_sum[16])
            accum <= add_sum[15:0];    // Hold on overflow
      end
      else if (accum_sub)
         accum <= sub_borrow ? '0 : accum - step;   // Floor at zero
   end

   assign duty    = accum[15:8];
   assign at_top  = (duty >= level);
   assign at_zero = (accum == '0);

   // Breathing duty never exceeds the configured level
   assign dest    = breathing ? ((duty < level) ? duty : level) : level;
   assign pwm_val = (pwm_cnt < dest) | (extend & (&dest));

   always_ff @(posedge ledd_clk or posedge ledd_rst_async)
   begin
      if (ledd_rst_async)
         pwm_out <= 1'b0;
      else if (!run)
         pwm_out <= 1'b0;
      else
         pwm_out <= pwm_val;
   end

   a_pwm_off: assert property (@(posedge ledd_clk) disable iff (ledd_rst_async)
      !$past(run) |-> !pwm_out)
      else $error("pwm_out high after run low");

endmodule

// File: verilog/ledd_top.sv
`timescale 1ns/1ps
module ledd_top
(
   input  logic             ledd_clk,
   input  logic             ledd_rst_async,
   input  logic             cfg_valid,
   input  logic             cfg_on,
   input  logic             cfg_breath,
   input  logic             cfg_extend,
   input  ledd_pkg::pwm_t   cfg_level,
   input  ledd_pkg::rate_t  cfg_rate,
   output logic             cfg_ready,
   output logic             pwm_out,
   output logic             frame_sync
);
   import ledd_pkg::*;

   logic run;
   logic breathing;
   logic extend;
   pwm_t level;
   pwm_t pwm_cnt;
   logic frame_end;
   logic mult_rst;
   logic mult_run;
   logic accum_rst;
   logic accum_add;
   logic accum_sub;
   logic at_top;
   logic at_zero;

   ledd_ctrl u_ctrl
   (
      .ledd_clk       (ledd_clk),
      .ledd_rst_async (ledd_rst_async),
      .cfg_valid      (cfg_valid),
      .cfg_on         (cfg_on),
      .cfg_breath     (cfg_breath),
      .cfg_extend     (cfg_extend),
      .cfg_level      (cfg_level),
      .cfg_rate       (cfg_rate),
      .frame_end      (frame_end),
      .at_top         (at_top),
      .at_zero        (at_zero),
      .cfg_ready      (cfg_ready),
      .run            (run),
      .breathing      (breathing),
      .extend         (extend),
      .level          (level),
      .mult_rst       (mult_rst),
      .mult_run       (mult_run),
      .accum_rst      (accum_rst),
      .accum_add      (accum_add),
      .accum_sub      (accum_sub)
   );

   // Frame timing
   ledd_pwm_cnt u_cnt
   (
      .ledd_clk       (ledd_clk),
      .ledd_rst_async (ledd_rst_async),
      .run            (run),
      .pwm_cnt        (pwm_cnt),
      .frame_end      (frame_end),
      .frame_sync     (frame_sync)
   );

   ledd_pwmc u_pwmc
   (
      .ledd_clk       (ledd_clk),
      .ledd_rst_async (ledd_rst_async),
      .run            (run),
      .breathing      (breathing),
      .extend         (extend),
      .level          (level),
      .pwm_cnt        (pwm_cnt),
      .mult_rst       (mult_rst),
      .mult_run       (mult_run),
      .accum_rst      (accum_rst),
      .accum_add      (accum_add),
      .accum_sub      (accum_sub),
      .pwm_out        (pwm_out),
      .at_top         (at_top),
      .at_zero        (at_zero)
   );

endmodule
